//--- hdl/max_pkg.sv
package max_pkg;

	// Flow control
	localparam int MAX_REQ_CREDITS = 4;     // Request queue depth
	localparam int MAX_RSP_CREDITS = 2;
	localparam int MAX_REQ_PTR_W   = $clog2(MAX_REQ_CREDITS);
	localparam int MAX_REQ_CNT_W   = $clog2(MAX_REQ_CREDITS + 1);
	localparam int MAX_RSP_CRED_W  = $clog2(MAX_RSP_CREDITS + 1);

	localparam int MAX_RESET_STRETCH = 255;  // Cycles held after all sources clear

	// Memory sizes
	localparam int MAX_RAM_DEPTH    = 2048;
	localparam int MAX_COLRAM_DEPTH = 1024;

	// Memory map, matched on the upper address bits
	localparam logic [4:0] MAP_RAM_HI    = 5'b00000;   // 0000-07FF
	localparam logic [5:0] MAP_COLRAM_HI = 6'b110110;  // D800-DBFF
	localparam logic [7:0] MAP_CIA_HI    = 8'hDC;      // DC00-DCFF

	// CRA bit positions
	localparam int CRA_START   = 0;
	localparam int CRA_ONESHOT = 3;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
	} max_req_t;

	typedef struct packed {
		logic [7:0] rdata;
		logic       wr;     // Echo of the request type
	} max_rsp_t;

	typedef struct packed {
		logic        valid;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} max_cyc_t;

	typedef enum logic [1:0] {
		RGN_RAM    = 2'd0,
		RGN_COLRAM = 2'd1,
		RGN_CIA    = 2'd2,
		RGN_OPEN   = 2'd3   // Nothing mapped here
	} max_region_e;

	typedef enum logic [3:0] {
		CIA_PRA = 4'd0,   // Keyboard columns out
		CIA_PRB = 4'd1,   // Keyboard rows in
		CIA_TAL = 4'd4,
		CIA_TAH = 4'd5,
		CIA_ICR = 4'd13,
		CIA_CRA = 4'd14
	} max_cia_reg_e;

endpackage

//--- hdl/max_reset_gen.sv
`timescale 1ns/1ps

module max_reset_gen import max_pkg::*; (
	input  logic clk_cpu,
	input  logic rst_n,
	input  logic pll_locked,
	input  logic reset_button,
	output logic sys_reset
);

	logic       hold;   // Any reset source active
	logic [7:0] cnt;

	assign hold = !rst_n || !pll_locked || reset_button;

	// Restarts from zero whenever a source is active
	always_ff @(posedge clk_cpu) begin
		if (hold) begin
			cnt <= 8'd0;
		end else if (cnt != 8'(MAX_RESET_STRETCH)) begin
			cnt <= cnt + 8'd1;
		end
	end

	assign sys_reset = hold || (cnt != 8'(MAX_RESET_STRETCH));

	// Saturates at the limit, never wraps back to zero on its own
	a_cnt_limit: assert property (
		@(posedge clk_cpu) disable iff (!rst_n)
		!hold |=> cnt != 8'd0
	);

endmodule

//--- hdl/max_pla.sv
`timescale 1ns/1ps

module max_pla import max_pkg::*; (
	input  max_cyc_t    cyc,
	output max_region_e region,
	output logic        ram_sel,
	output logic        colram_sel,
	output logic        cia_sel
);

	// Region decode from the upper address bits
	always_comb begin
		if (cyc.addr[15:11] == MAP_RAM_HI) begin
			region = RGN_RAM;
		end else if (cyc.addr[15:10] == MAP_COLRAM_HI) begin
			region = RGN_COLRAM;
		end else if (cyc.addr[15:8] == MAP_CIA_HI) begin
			region = RGN_CIA;   // 16 registers, mirrored
		end else begin
			region = RGN_OPEN;
		end
	end

	// Strobes only for a live cycle
	assign ram_sel    = cyc.valid && (region == RGN_RAM);
	assign colram_sel = cyc.valid && (region == RGN_COLRAM);
	assign cia_sel    = cyc.valid && (region == RGN_CIA);

	// Each select stays inside its own address range, so at most one is high
	always_comb begin
		if (!$isunknown(cyc.valid)) begin
			a_sel_map: assert final (
				(!ram_sel || cyc.addr < 16'h0800)
				&& (!colram_sel || (cyc.addr >= 16'hD800 && cyc.addr <= 16'hDBFF))
				&& (!cia_sel || (cyc.addr >= 16'hDC00 && cyc.addr <= 16'hDCFF))
			);
		end
	end

endmodule

//--- hdl/max_ram.sv
`timescale 1ns/1ps

module max_ram #(
	parameter int DEPTH = 2048,
	parameter int WIDTH = 8
) (
	input  logic                     clk_cpu,
	input  logic                     sel,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         wdata,
	output logic [WIDTH-1:0]         rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Single port, read data holds until the next read
	always_ff @(posedge clk_cpu) begin
		if (sel) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

//--- hdl/max_cia.sv
`timescale 1ns/1ps

module max_cia import max_pkg::*; (
	input  logic       clk_cpu,
	input  logic       rst_n,
	input  logic       sys_reset,
	input  logic       sel,
	input  max_cyc_t   cyc,
	input  logic [7:0] kbd_rows,
	output logic [7:0] rdata,
	output logic [7:0] kbd_cols,
	output logic       irq_n
);

	max_cia_reg_e reg_sel;
	logic         wr_en;
	logic         rd_en;
	logic [15:0]  latch;
	logic [15:0]  counter;
	logic         start;
	logic         oneshot;
	logic         flag;       // Timer A interrupt flag
	logic         mask;
	logic         underflow;

	assign reg_sel   = max_cia_reg_e'(cyc.addr[3:0]);
	assign wr_en     = sel && cyc.wr;
	assign rd_en     = sel && !cyc.wr;
	assign underflow = start && (counter == 16'd0);

	always_ff @(posedge clk_cpu) begin
		if (!rst_n || sys_reset) begin
			kbd_cols <= 8'h00;
			latch    <= 16'd0;
			counter  <= 16'd0;
			start    <= 1'b0;
			oneshot  <= 1'b0;
			flag     <= 1'b0;
			mask     <= 1'b0;
		end else begin
			if (wr_en) begin
				case (reg_sel)
					CIA_PRA: kbd_cols    <= cyc.wdata;
					CIA_TAL: latch[7:0]  <= cyc.wdata;
					CIA_TAH: latch[15:8] <= cyc.wdata;
					CIA_ICR: mask        <= cyc.wdata[0];
					default: ;
				endcase
			end

			// Timer, a CRA write takes priority
			if (wr_en && reg_sel == CIA_CRA) begin
				start   <= cyc.wdata[CRA_START];
				oneshot <= cyc.wdata[CRA_ONESHOT];
				if (cyc.wdata[CRA_START]) begin
					counter <= latch;
				end
			end else if (underflow) begin
				counter <= latch;   // Reload
				if (oneshot) begin
					start <= 1'b0;
				end
			end else if (start) begin
				counter <= counter - 16'd1;
			end

			// Set beats the read clear
			if (underflow) begin
				flag <= 1'b1;
			end else if (rd_en && reg_sel == CIA_ICR) begin
				flag <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rd_en) begin
			case (reg_sel)
				CIA_PRA: rdata <= kbd_cols;
				CIA_PRB: rdata <= kbd_rows;
				CIA_TAL: rdata <= counter[7:0];
				CIA_TAH: rdata <= counter[15:8];
				CIA_ICR: rdata <= {flag && mask, 6'd0, flag};
				CIA_CRA: rdata <= {4'd0, oneshot, 2'd0, start};
				default: rdata <= 8'h00;
			endcase
		end
	end

	assign irq_n = !(flag && mask);

	// Flag only comes from a running timer
	a_flag_running: assert property (
		@(posedge clk_cpu) disable iff (!rst_n || sys_reset)
		$rose(flag) |-> $past(start)
	);

endmodule

//--- hdl/max_bus_ctrl.sv
`timescale 1ns/1ps

module max_bus_ctrl import max_pkg::*; (
	input  logic        clk_cpu,
	input  logic        rst_n,
	input  logic        sys_reset,
	input  logic        req_valid,
	input  max_req_t    req,
	input  logic        rsp_credit,
	input  max_region_e region,
	input  logic [7:0]  ram_rdata,
	input  logic [3:0]  colram_rdata,
	input  logic [7:0]  cia_rdata,
	output logic        req_credit,
	output max_cyc_t    cyc,
	output logic        rsp_valid,
	output max_rsp_t    rsp
);

	max_req_t                  queue [MAX_REQ_CREDITS];
	logic [MAX_REQ_PTR_W-1:0]  wr_ptr;
	logic [MAX_REQ_PTR_W-1:0]  rd_ptr;
	logic [MAX_REQ_CNT_W-1:0]  q_count;
	logic [MAX_RSP_CRED_W-1:0] rsp_cred;   // Includes responses still in flight
	logic                      run;
	logic                      push;
	logic                      pop;
	max_region_e               rsp_rgn;
	logic                      rsp_wr;

	assign run  = rst_n && !sys_reset;
	assign push = run && req_valid;
	assign pop  = (q_count != '0) && (rsp_cred != '0);

	always_ff @(posedge clk_cpu) begin
		if (push) begin
			queue[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (!run) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			rsp_cred   <= MAX_RSP_CRED_W'(MAX_RSP_CREDITS);
			req_credit <= 1'b0;
			cyc.valid  <= 1'b0;
			rsp_valid  <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == MAX_REQ_PTR_W'(MAX_REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr    <= (rd_ptr == MAX_REQ_PTR_W'(MAX_REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
				cyc.wr    <= queue[rd_ptr].wr;
				cyc.addr  <= queue[rd_ptr].addr;
				cyc.wdata <= queue[rd_ptr].wdata;
			end
			cyc.valid  <= pop;
			req_credit <= pop;        // Slot freed, credit back to master
			rsp_valid  <= cyc.valid;  // Device data arrives with this

			case ({push, pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: ;
			endcase

			case ({pop, rsp_credit})
				2'b10:   rsp_cred <= rsp_cred - 1'b1;
				2'b01:   rsp_cred <= rsp_cred + 1'b1;
				default: ;
			endcase
		end
	end

	// Region and type of the cycle on the bus, used for the response
	always_ff @(posedge clk_cpu) begin
		rsp_rgn <= region;
		rsp_wr  <= cyc.wr;
	end

	always_comb begin
		rsp.wr = rsp_wr;
		if (rsp_wr) begin
			rsp.rdata = 8'h00;
		end else begin
			case (rsp_rgn)
				RGN_RAM:    rsp.rdata = ram_rdata;
				RGN_COLRAM: rsp.rdata = {4'hF, colram_rdata};
				RGN_CIA:    rsp.rdata = cia_rdata;
				default:    rsp.rdata = 8'hFF;   // Open bus
			endcase
		end
	end

	// A full queue can only take a request if one leaves the same cycle
	a_no_overflow: assert property (
		@(posedge clk_cpu) disable iff (!run)
		(req_valid && q_count == MAX_REQ_CREDITS) |-> pop
	);

	a_rsp_cred: assert property (
		@(posedge clk_cpu) disable iff (!run)
		rsp_cred <= MAX_RSP_CREDITS
	);

endmodule

//--- hdl/max_top.sv
`timescale 1ns/1ps

module max_top import max_pkg::*; (
	input  logic       clk_cpu,
	input  logic       rst_n,
	input  logic       pll_locked,
	input  logic       reset_button,
	input  logic       req_valid,
	input  logic       rsp_credit,
	input  max_req_t   req,
	input  logic [7:0] kbd_rows,
	output logic       sys_reset,
	output logic       req_credit,
	output logic       rsp_valid,
	output logic       irq_n,
	output max_rsp_t   rsp,
	output logic [7:0] kbd_cols
);

	max_cyc_t    cyc;
	max_region_e region;
	logic        ram_sel;
	logic        colram_sel;
	logic        cia_sel;
	logic [7:0]  ram_rdata;
	logic [3:0]  colram_rdata;
	logic [7:0]  cia_rdata;

	max_reset_gen reset_gen_i (
		.clk_cpu      (clk_cpu),
		.rst_n        (rst_n),
		.pll_locked   (pll_locked),
		.reset_button (reset_button),
		.sys_reset    (sys_reset)
	);

	// Bus master side
	max_bus_ctrl bus_ctrl_i (
		.clk_cpu      (clk_cpu),
		.rst_n        (rst_n),
		.sys_reset    (sys_reset),
		.req_valid    (req_valid),
		.req          (req),
		.rsp_credit   (rsp_credit),
		.region       (region),
		.ram_rdata    (ram_rdata),
		.colram_rdata (colram_rdata),
		.cia_rdata    (cia_rdata),
		.req_credit   (req_credit),
		.cyc          (cyc),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp)
	);

	max_pla pla_i (
		.cyc        (cyc),
		.region     (region),
		.ram_sel    (ram_sel),
		.colram_sel (colram_sel),
		.cia_sel    (cia_sel)
	);

	// Main RAM 2048x8
	max_ram #(.DEPTH(MAX_RAM_DEPTH), .WIDTH(8)) main_ram_i (
		.clk_cpu (clk_cpu),
		.sel     (ram_sel),
		.we      (cyc.wr),
		.addr    (cyc.addr[$clog2(MAX_RAM_DEPTH)-1:0]),
		.wdata   (cyc.wdata),
		.rdata   (ram_rdata)
	);

	// Colour RAM 1024x4, low nibble only
	max_ram #(.DEPTH(MAX_COLRAM_DEPTH), .WIDTH(4)) col_ram_i (
		.clk_cpu (clk_cpu),
		.sel     (colram_sel),
		.we      (cyc.wr),
		.addr    (cyc.addr[$clog2(MAX_COLRAM_DEPTH)-1:0]),
		.wdata   (cyc.wdata[3:0]),
		.rdata   (colram_rdata)
	);

	max_cia cia_i (
		.clk_cpu   (clk_cpu),
		.rst_n     (rst_n),
		.sys_reset (sys_reset),
		.sel       (cia_sel),
		.cyc       (cyc),
		.kbd_rows  (kbd_rows),
		.rdata     (cia_rdata),
		.kbd_cols  (kbd_cols),
		.irq_n     (irq_n)
	);

endmodule

//--- bench/max_tb.sv
`timescale 1ns/1ps

module max_tb import max_pkg::*;;

	localparam int RAND_OPS  = 400;
	localparam int FILL_OPS  = MAX_RAM_DEPTH + MAX_COLRAM_DEPTH;
	// About four cycles per bus op at worst, both reset stretches, small tests
	localparam int WD_CYCLES = 2 * (MAX_RESET_STRETCH + 20)
		+ 4 * (FILL_OPS + RAND_OPS) + 1500;

	typedef struct packed {
		logic [7:0]  data;
		logic [7:0]  mask;   // Bits of rdata that are checked
		logic        wr;
		logic [31:0] cnt;    // Cycle count when driven
	} exp_t;

	logic        clk_cpu;
	logic        rst_n;
	logic        pll_locked;
	logic        reset_button;
	logic        req_valid;
	logic        rsp_credit;
	max_req_t    req;
	logic [7:0]  kbd_rows;
	logic        sys_reset;
	logic        req_credit;
	logic        rsp_valid;
	logic        irq_n;
	max_rsp_t    rsp;
	logic [7:0]  kbd_cols;

	logic [7:0]  ram_m [MAX_RAM_DEPTH];
	logic [3:0]  col_m [MAX_COLRAM_DEPTH];
	exp_t        exp_q [$];
	exp_t        got_e;
	logic [31:0] seed = 32'hb4abf59a;
	logic [31:0] cyc_cnt = 0;
	int          sent = 0;
	int          returned = 0;
	int          rsp_held = 0;     // Responses not yet credited
	logic        credit_on = 1'b1;
	logic        timing_on = 1'b0;
	int          errors = 0;
	int          test_num = 0;
	int          test_fails = 0;
	int          err_mark = 0;

	max_top dut_i (
		.clk_cpu      (clk_cpu),
		.rst_n        (rst_n),
		.pll_locked   (pll_locked),
		.reset_button (reset_button),
		.req_valid    (req_valid),
		.rsp_credit   (rsp_credit),
		.req          (req),
		.kbd_rows     (kbd_rows),
		.sys_reset    (sys_reset),
		.req_credit   (req_credit),
		.rsp_valid    (rsp_valid),
		.irq_n        (irq_n),
		.rsp          (rsp),
		.kbd_cols     (kbd_cols)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #5 clk_cpu = ~clk_cpu;
	end

	always @(posedge clk_cpu) cyc_cnt <= cyc_cnt + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic logic [15:0] rand_addr(input logic [31:0] r);
		case (r[17:16])
			2'd0, 2'd1: return {5'b00000, r[10:0]};
			2'd2:       return {6'b110110, r[9:0]};
			default:    return r[15] ? {5'b00001, r[10:0]} : {3'b111, r[12:0]};  // Unmapped
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] got);
		assert (got === exp_v) else begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, got);
			errors++;
		end
	endtask

	// One request per call, blocks while no request credit is held
	task automatic send_req(input logic [15:0] addr, input logic [7:0] wdata, input logic wr,
			input logic [7:0] exp_data, input logic [7:0] exp_mask);
		exp_t e;
		while (sent - returned >= MAX_REQ_CREDITS) begin
			@(negedge clk_cpu);
		end
		req_valid = 1'b1;
		req = '{addr: addr, wdata: wdata, wr: wr};
		e = '{data: exp_data, mask: exp_mask, wr: wr, cnt: cyc_cnt};
		exp_q.push_back(e);
		sent++;
		@(negedge clk_cpu);
		req_valid = 1'b0;
	endtask

	// Reference model of the memory map
	task automatic send_op(input logic [15:0] addr, input logic wr, input logic [7:0] wdata);
		logic [7:0] exp_data;
		logic [7:0] exp_mask;
		exp_data = 8'hFF;
		exp_mask = wr ? 8'h00 : 8'hFF;
		if (addr[15:11] == 5'b00000) begin
			ram_m[addr[10:0]] = wr ? wdata : ram_m[addr[10:0]];
			exp_data = ram_m[addr[10:0]];
		end else if (addr[15:10] == 6'b110110) begin
			col_m[addr[9:0]] = wr ? wdata[3:0] : col_m[addr[9:0]];
			exp_data = {4'hF, col_m[addr[9:0]]};
		end else if (addr[15:8] == 8'hDC) begin
			exp_mask = 8'h00;
		end
		send_req(addr, wdata, wr, exp_data, exp_mask);
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0) begin
			@(negedge clk_cpu);
		end
		@(negedge clk_cpu);   // Last credit back in the DUT
	endtask

	task automatic measure_stretch(output int n);
		n = 0;
		while (sys_reset && n < 2 * MAX_RESET_STRETCH) begin
			@(negedge clk_cpu);
			n++;
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (errors != err_mark) begin
			test_fails++;
		end
		$display("test %0d %s %0d errors", test_num, name, errors - err_mark);
		err_mark = errors;
	endtask

	// Response checker and credit bookkeeping of the master
	initial begin
		rsp_credit = 1'b0;
		forever begin
			@(negedge clk_cpu);
			if (req_credit) begin
				returned++;
			end
			if (rsp_valid) begin
				rsp_held++;
				if (exp_q.size() == 0) begin
					$display("Response at %0t with no request outstanding", $time);
					errors++;
				end else begin
					got_e = exp_q.pop_front();
					compare("rsp.wr", got_e.wr, rsp.wr);
					compare("rsp.rdata", got_e.data & got_e.mask, rsp.rdata & got_e.mask);
					if (timing_on) begin
						compare("rsp latency", 2, cyc_cnt - got_e.cnt - 1);
					end
				end
			end
			assert (rsp_held <= MAX_RSP_CREDITS) else begin
				$display("More responses than response credits at %0t", $time);
				errors++;
			end
			rsp_credit = credit_on && (rsp_held > 0);
			rsp_held = rsp_credit ? rsp_held - 1 : rsp_held;
		end
	end

	// Every credit pulse must stand for a request that was sent
	a_req_credits: assert property (
		@(posedge clk_cpu) returned <= sent
	) else begin
		$display("Request credit returned with no request outstanding at %0t", $time);
		errors++;
	end

	a_quiet_reset: assert property (
		@(posedge clk_cpu) sys_reset |=> !rsp_valid && !req_credit
	) else begin
		$display("Response or credit during reset at %0t", $time);
		errors++;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk_cpu);
		$display("Timeout after %0d cycles, run stopped", WD_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [7:0]  v;
		logic [31:0] t_start;
		int          n;
		logic        seen_low;
		rst_n = 1'b0;
		pll_locked = 1'b0;
		reset_button = 1'b0;
		req_valid = 1'b0;
		req = '0;
		kbd_rows = 8'h00;

		repeat (3) @(negedge clk_cpu);
		rst_n = 1'b1;
		@(negedge clk_cpu);
		compare("rsp_valid", 0, rsp_valid);
		compare("req_credit", 0, req_credit);
		compare("kbd_cols", 0, kbd_cols);
		compare("irq_n", 1, irq_n);
		pll_locked = 1'b1;
		measure_stretch(n);
		compare("sys_reset stretch", MAX_RESET_STRETCH, n);
		reset_button = 1'b1;
		@(negedge clk_cpu);
		compare("sys_reset", 1, sys_reset);
		reset_button = 1'b0;
		measure_stretch(n);
		compare("sys_reset stretch", MAX_RESET_STRETCH, n);
		end_test("reset");

		for (int a = 0; a < MAX_RAM_DEPTH; a++) begin
			send_op(16'(a), 1'b1, 8'(a ^ (a >> 5)));
		end
		for (int a = 0; a < MAX_COLRAM_DEPTH; a++) begin
			send_op(16'hD800 + 16'(a), 1'b1, 8'(a ^ (a >> 4) ^ (a >> 8)));
		end
		for (int i = 0; i < RAND_OPS; i++) begin
			r = next_rand();
			send_op(rand_addr(r), r[18], r[31:24]);
		end
		wait_idle();
		end_test("memory map");

		// Bursts of two, full credits each time
		timing_on = 1'b1;
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			send_op({5'b00000, r[10:0]}, r[11], r[19:12]);
			send_op({5'b00000, r[30:20]}, 1'b0, 8'h00);
			wait_idle();
		end
		timing_on = 1'b0;
		end_test("pipeline");

		credit_on = 1'b0;
		for (int i = 0; i < MAX_REQ_CREDITS + MAX_RSP_CREDITS; i++) begin
			r = next_rand();
			send_op({5'b00000, r[10:0]}, r[11], r[19:12]);
		end
		repeat (20) @(negedge clk_cpu);
		compare("outstanding requests", MAX_REQ_CREDITS, exp_q.size());
		compare("request credits held", 0, MAX_REQ_CREDITS - (sent - returned));
		credit_on = 1'b1;
		wait_idle();
		end_test("credit flow");

		r = next_rand();
		v = r[7:0];
		kbd_rows = r[15:8];
		send_req(16'hDC00, v, 1'b1, 8'h00, 8'h00);
		send_req(16'hDC01, 8'h00, 1'b0, r[15:8], 8'hFF);
		send_req(16'hDC30, 8'h00, 1'b0, v, 8'hFF);   // PRA through a mirror
		wait_idle();
		compare("kbd_cols", v, kbd_cols);
		end_test("keyboard");

		r = next_rand();
		n = 5 + int'(r[4:0]);
		send_req(16'hDC04, 8'(n), 1'b1, 8'h00, 8'h00);
		send_req(16'hDC05, 8'h00, 1'b1, 8'h00, 8'h00);
		send_req(16'hDC0D, 8'h01, 1'b1, 8'h00, 8'h00);   // Mask on
		wait_idle();
		t_start = cyc_cnt;
		send_req(16'hDC0E, 8'h09, 1'b1, 8'h00, 8'h00);   // One-shot start
		while (irq_n && cyc_cnt < t_start + n + 20) begin
			@(negedge clk_cpu);
		end
		// Sample edge, two edges to reach the CIA, then N+1 of countdown
		compare("irq_n fall cycle", t_start + 1 + 2 + n + 1, cyc_cnt);
		send_req(16'hDC0D, 8'h00, 1'b0, 8'h01, 8'h01);
		wait_idle();
		compare("irq_n", 1, irq_n);
		send_req(16'hDC0D, 8'h00, 1'b1, 8'h00, 8'h00);   // Mask off
		send_req(16'hDC0E, 8'h09, 1'b1, 8'h00, 8'h00);
		seen_low = 1'b0;
		repeat (n + 10) begin
			@(negedge clk_cpu);
			seen_low = seen_low || !irq_n;
		end
		compare("irq_n low while masked", 0, seen_low);
		wait_idle();
		end_test("timer irq");

		$display("%0d tests, %0d failed, %0d errors", test_num, test_fails, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
hdl/max_pkg.sv
hdl/max_reset_gen.sv
hdl/max_pla.sv
hdl/max_ram.sv
hdl/max_cia.sv
hdl/max_bus_ctrl.sv
hdl/max_top.sv
bench/max_tb.sv

//--- Bender.yml
package:
  name: max_core

sources:
  - hdl/max_pkg.sv
  - hdl/max_reset_gen.sv
  - hdl/max_pla.sv
  - hdl/max_ram.sv
  - hdl/max_cia.sv
  - hdl/max_bus_ctrl.sv
  - hdl/max_top.sv
  - target: test
    files:
      - bench/max_tb.sv
